//--- sources.f
src/gamePkg.sv
src/letterPkg.sv
src/keyDecoder.sv
src/wordRegister.sv
src/gameLogic.sv
src/hangmanTop.sv
tests/gameLogic_props.sv
tests/hangmanTb.sv

//--- src/gameLogic.sv
module gameLogic (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic                           gameEnd,
    input  logic                           start,
    input  logic                           wordFull,
    input  letterPkg::letterT              guess,
    input  letterPkg::secretWordT          secretWord,
    output letterPkg::letterT              letter,
    output logic                           red,
    output logic                           green,
    output logic                           mistake,
    output logic                           busy,
    output logic                           gameRdy,
    output logic                           wordOpen,
    output logic [gamePkg::countWidth-1:0] incorrect,
    output logic [gamePkg::countWidth-1:0] correct,
    output logic [gamePkg::wordLen-1:0]    indexCorrect
);
    import gamePkg::*;
    import letterPkg::*;

    gameStateT               state;
    gameStateT               nextState;
    gameStateT               scanNext;
    letterT                  nextLetter;
    logic [countWidth-1:0]   hits;
    logic [countWidth-1:0]   nextHits;
    logic [countWidth-1:0]   nextCorrect;
    logic [countWidth-1:0]   nextIncorrect;
    logic [wordLen-1:0]      nextIndexCorrect;
    logic                    nextRed;
    logic                    nextGreen;
    logic [2:0]              pos;
    logic                    gameOver;

    // word position checked by each scan state
    always_comb begin
        case (state)
            L0: begin
                pos      = 3'd4;
                scanNext = L1;
            end
            L1: begin
                pos      = 3'd3;
                scanNext = L2;
            end
            L2: begin
                pos      = 3'd2;
                scanNext = L3;
            end
            L3: begin
                pos      = 3'd1;
                scanNext = L4;
            end
            default: begin
                pos      = 3'd0;
                scanNext = STOP;
            end
        endcase
    end

    assign gameOver = (correct == winCount) || (incorrect == loseCount);

    assign busy     = state inside {L0, L1, L2, L3, L4};
    assign gameRdy  = state inside {FIRST, STOP, IDLE};
    assign wordOpen = (state == SET);

    always_comb begin
        nextState        = state;
        nextLetter       = letter;
        nextHits         = hits;
        nextCorrect      = correct;
        nextIncorrect    = incorrect;
        nextIndexCorrect = indexCorrect;
        nextRed          = red;
        nextGreen        = green;
        mistake          = 1'b0;

        case (state)
            SET: begin
                nextLetter       = '0;
                nextHits         = '0;
                nextCorrect      = '0;
                nextIncorrect    = '0;
                nextIndexCorrect = '0;
                nextRed          = 1'b0;
                nextGreen        = 1'b0;
                if (start && wordFull) begin
                    nextState = FIRST;
                end
            end
            FIRST: begin
                if (guess != '0) begin
                    nextLetter = guess;
                    nextState  = L0;
                end
            end
            L0, L1, L2, L3, L4: begin
                if ((letter == secretWord.letters[pos]) && !indexCorrect[pos]) begin
                    nextIndexCorrect[pos] = 1'b1;
                    nextHits              = hits + 1'b1;
                end
                nextState = scanNext;
            end
            STOP: begin
                if ((correct < winCount) && (incorrect < loseCount)) begin
                    if (hits != '0) begin
                        nextCorrect = correct + hits;
                    end else begin
                        mistake       = 1'b1;  // nothing new revealed
                        nextIncorrect = incorrect + 1'b1;
                    end
                end
                nextHits  = '0;
                nextState = IDLE;
            end
            IDLE: begin
                nextGreen = (correct == winCount);
                nextRed   = (incorrect == loseCount);
                if ((guess != '0) && !gameOver) begin  // dropped once decided
                    nextLetter = guess;
                    nextState  = L0;
                end
            end
            default: begin
                nextState = SET;
            end
        endcase

        if (gameEnd) begin
            nextState        = SET;
            nextLetter       = '0;
            nextHits         = '0;
            nextCorrect      = '0;
            nextIncorrect    = '0;
            nextIndexCorrect = '0;
            nextRed          = 1'b0;
            nextGreen        = 1'b0;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= SET;
            letter       <= '0;
            hits         <= '0;
            correct      <= '0;
            incorrect    <= '0;
            indexCorrect <= '0;
            red          <= 1'b0;
            green        <= 1'b0;
        end else begin
            state        <= nextState;
            letter       <= nextLetter;
            hits         <= nextHits;
            correct      <= nextCorrect;
            incorrect    <= nextIncorrect;
            indexCorrect <= nextIndexCorrect;
            red          <= nextRed;
            green        <= nextGreen;
        end
    end

endmodule

//--- src/gamePkg.sv
package gamePkg;

    localparam int wordLen    = 5;
    localparam int winCount   = 5;  // every position revealed
    localparam int loseCount  = 6;
    localparam int countWidth = 3;

    // scan states L0..L4 follow each other in the encoding
    typedef enum logic [3:0] {
        SET   = 4'd0,
        FIRST = 4'd1,
        L0    = 4'd2,
        L1    = 4'd3,
        L2    = 4'd4,
        L3    = 4'd5,
        L4    = 4'd6,
        STOP  = 4'd7,
        IDLE  = 4'd8
    } gameStateT;

endpackage

//--- src/hangmanTop.sv
module hangmanTop (
    input  logic                               clk,
    input  logic                               nRst,
    input  logic [letterPkg::keyCodeWidth-1:0] keyCode,
    input  logic                               keyPress,
    input  logic                               start,
    input  logic                               gameEnd,
    output letterPkg::letterT                  letter,
    output logic                               red,
    output logic                               green,
    output logic                               mistake,
    output logic                               busy,
    output logic                               gameRdy,
    output logic                               wordFull,
    output logic [gamePkg::countWidth-1:0]     incorrect,
    output logic [gamePkg::countWidth-1:0]     correct,
    output logic [gamePkg::wordLen-1:0]        indexCorrect
);
    import letterPkg::*;

    letterT     letterStrobe;  // also the guess
    secretWordT secretWord;
    logic       wordOpen;

    keyDecoder u_keyDecoder (
        .clk          (clk),
        .nRst         (nRst),
        .keyCode      (keyCode),
        .keyPress     (keyPress),
        .letterStrobe (letterStrobe)
    );

    wordRegister u_wordRegister (
        .clk        (clk),
        .nRst       (nRst),
        .letterIn   (letterStrobe),
        .wordOpen   (wordOpen),
        .gameEnd    (gameEnd),
        .secretWord (secretWord),
        .wordFull   (wordFull)
    );

    gameLogic u_gameLogic (
        .clk          (clk),
        .nRst         (nRst),
        .gameEnd      (gameEnd),
        .start        (start),
        .wordFull     (wordFull),
        .guess        (letterStrobe),
        .secretWord   (secretWord),
        .letter       (letter),
        .red          (red),
        .green        (green),
        .mistake      (mistake),
        .busy         (busy),
        .gameRdy      (gameRdy),
        .wordOpen     (wordOpen),
        .incorrect    (incorrect),
        .correct      (correct),
        .indexCorrect (indexCorrect)
    );

endmodule

//--- src/keyDecoder.sv
module keyDecoder (
    input  logic                               clk,
    input  logic                               nRst,
    input  logic [letterPkg::keyCodeWidth-1:0] keyCode,
    input  logic                               keyPress,
    output letterPkg::letterT                  letterStrobe
);
    import letterPkg::*;

    logic                    pressMeta;
    logic                    pressSync;
    logic                    pressPrev;
    logic [keyCodeWidth-1:0] codeMeta;
    logic [keyCodeWidth-1:0] codeSync;
    logic                    pressRise;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pressMeta <= 1'b0;
            pressSync <= 1'b0;
            pressPrev <= 1'b0;
        end else begin
            pressMeta <= keyPress;
            pressSync <= pressMeta;
            pressPrev <= pressSync;  // edge detect
        end
    end

    // code follows the same two stages as the press
    always_ff @(posedge clk) begin
        codeMeta <= keyCode;
        codeSync <= codeMeta;
    end

    assign pressRise = pressSync && !pressPrev;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            letterStrobe <= '0;
        end else if (pressRise && (codeSync < alphabetSize)) begin
            letterStrobe <= letterBase + letterT'(codeSync);
        end else begin
            letterStrobe <= '0;  // single cycle strobe
        end
    end

endmodule

//--- src/letterPkg.sv
package letterPkg;

    typedef logic [7:0] letterT;  // ascii code or zero for none

    localparam letterT letterBase   = 8'h41;  // 'A'
    localparam int     alphabetSize = 26;
    localparam int     keyCodeWidth = 5;

    // flat view for shifting, letter view for comparing
    typedef union packed {
        logic [gamePkg::wordLen*$bits(letterT)-1:0] flat;
        letterT [gamePkg::wordLen-1:0]              letters;  // [4] holds the first letter
    } secretWordT;

endpackage

//--- src/wordRegister.sv
module wordRegister (
    input  logic                  clk,
    input  logic                  nRst,
    input  letterPkg::letterT     letterIn,
    input  logic                  wordOpen,
    input  logic                  gameEnd,
    output letterPkg::secretWordT secretWord,
    output logic                  wordFull
);
    import gamePkg::*;
    import letterPkg::*;

    logic [$clog2(wordLen+1)-1:0] fillCount;
    logic                         accept;

    assign accept   = wordOpen && !wordFull && (letterIn != '0);
    assign wordFull = (fillCount == wordLen);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            fillCount <= '0;
        end else if (gameEnd) begin
            fillCount <= '0;
        end else if (accept) begin
            fillCount <= fillCount + 1'b1;
        end
    end

    // new letter enters at the bottom, first letter ends up in letters[4]
    always_ff @(posedge clk) begin
        if (gameEnd) begin
            secretWord.flat <= '0;
        end else if (accept) begin
            secretWord.flat <= {secretWord.flat[$bits(secretWordT)-$bits(letterT)-1:0],
                                letterIn};
        end
    end

endmodule

//--- tests/gameLogic_props.sv
module gameLogicProps (
    input  logic                           clk,
    input  logic                           nRst,
    input  gamePkg::gameStateT             state,
    input  logic                           busy,
    input  logic                           gameRdy,
    input  logic                           mistake,
    input  logic                           red,
    input  logic                           green,
    input  logic [gamePkg::countWidth-1:0] correct,
    input  logic [gamePkg::countWidth-1:0] incorrect
);
    timeunit 1ns;
    timeprecision 100ps;
    import gamePkg::*;

    busyRdyExclusive: assert property (@(posedge clk) disable iff (!nRst)
        !(busy && gameRdy))
        else $error("busy and gameRdy high together");

    mistakeInStop: assert property (@(posedge clk) disable iff (!nRst)
        mistake |-> (state == STOP))
        else $error("mistake outside STOP");

    lampsExclusive: assert property (@(posedge clk) disable iff (!nRst)
        !(red && green))
        else $error("red and green lit together");

    countsBounded: assert property (@(posedge clk) disable iff (!nRst)
        (correct <= loseCount) && (incorrect <= loseCount))
        else $error("count above its limit");

endmodule

bind gameLogic gameLogicProps u_gameLogicProps (
    .clk       (clk),
    .nRst      (nRst),
    .state     (state),
    .busy      (busy),
    .gameRdy   (gameRdy),
    .mistake   (mistake),
    .red       (red),
    .green     (green),
    .correct   (correct),
    .incorrect (incorrect)
);

//--- tests/hangmanTb.sv
module hangmanTb;
    timeunit 1ns;
    timeprecision 100ps;
    import gamePkg::*;
    import letterPkg::*;

    logic                    clk = 1'b0;
    logic                    nRst;
    logic [keyCodeWidth-1:0] keyCode;
    logic                    keyPress;
    logic                    start;
    logic                    gameEnd;
    letterT                  letter;
    logic                    red;
    logic                    green;
    logic                    mistake;
    logic                    busy;
    logic                    gameRdy;
    logic                    wordFull;
    logic [countWidth-1:0]   incorrect;
    logic [countWidth-1:0]   correct;
    logic [wordLen-1:0]      indexCorrect;

    logic [31:0]        lfsr = 32'h18fe_2201;
    logic [39:0]        expWord;  // first letter in the top byte
    logic [wordLen-1:0] expMask;
    int                 expCorrect;
    int                 expIncorrect;
    int                 expMistakes;
    int                 expBusyCycles;
    letterT             expLetter;
    logic               expGreen;
    logic               expRed;
    int                 obsMistakes;
    int                 obsBusyCycles;
    string              testName;
    int                 checkCount = 0;
    int                 valueErrors = 0;
    int                 timeouts = 0;
    event               checkEv;

    always #20 clk = ~clk;

    hangmanTop u_hangmanTop (
        .clk          (clk),
        .nRst         (nRst),
        .keyCode      (keyCode),
        .keyPress     (keyPress),
        .start        (start),
        .gameEnd      (gameEnd),
        .letter       (letter),
        .red          (red),
        .green        (green),
        .mistake      (mistake),
        .busy         (busy),
        .gameRdy      (gameRdy),
        .wordFull     (wordFull),
        .incorrect    (incorrect),
        .correct      (correct),
        .indexCorrect (indexCorrect)
    );

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // taps 32 30 26 25
    endfunction

    task automatic randomCode(output logic [keyCodeWidth-1:0] code);
        logic [7:0] raw;
        raw = '0;
        repeat (8) begin
            raw  = {raw[6:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        code = keyCodeWidth'(raw % alphabetSize);
    endtask

    function automatic bit inWord(input logic [39:0] word, input letterT g);
        for (int p = 0; p < wordLen; p++) begin
            if (word[p*8 +: 8] == g) return 1'b1;
        end
        return 1'b0;
    endfunction

    // expected mask, new hits and mistake flag for one guess
    function automatic void refGuess(input logic [39:0] word, input logic [wordLen-1:0] maskIn,
                                     input letterT g, output logic [wordLen-1:0] maskOut,
                                     output int hits, output bit isMistake);
        maskOut = maskIn;
        hits    = 0;
        for (int p = 0; p < wordLen; p++) begin
            if ((word[p*8 +: 8] == g) && !maskIn[p]) begin
                maskOut[p] = 1'b1;
                hits++;
            end
        end
        isMistake = (hits == 0);
    endfunction

    function automatic logic [keyCodeWidth-1:0] codeAt(input int i);
        letterT l;
        l = expWord[(wordLen-1-i)*8 +: 8];  // i = 0 is the first letter
        return keyCodeWidth'(l - letterBase);
    endfunction

    function automatic logic [keyCodeWidth-1:0] absentCode(input logic [keyCodeWidth-1:0] seed);
        int c;
        for (int k = 0; k < alphabetSize; k++) begin
            c = (seed + k) % alphabetSize;
            if (!inWord(expWord, letterBase + letterT'(c))) return keyCodeWidth'(c);
        end
        return seed;
    endfunction

    task automatic compareValue(input string name, input string field,
                                input logic [39:0] expV, input logic [39:0] actV);
        checkCount++;
        assert (actV === expV) else begin
            valueErrors++;
            $display("FAILED %s %s expected %0h actual %0h", name, field, expV, actV);
        end
    endtask

    task automatic clearModel();
        expMask      = '0;
        expCorrect   = 0;
        expIncorrect = 0;
        expMistakes  = 0;
        expLetter    = '0;
        expGreen     = 1'b0;
        expRed       = 1'b0;
    endtask

    task automatic holdKey(input logic [keyCodeWidth-1:0] code);
        keyCode  = code;
        keyPress = 1'b1;
        repeat (4) @(posedge clk);
        #2 keyPress = 1'b0;
    endtask

    task automatic releaseGap();
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic loadWord(input string name);
        logic [keyCodeWidth-1:0] code;
        int                      n;
        expWord = '0;
        for (int i = 0; i < wordLen; i++) begin
            randomCode(code);
            expWord = {expWord[31:0], letterBase + letterT'(code)};
            holdKey(code);
            releaseGap();
        end
        n = 0;
        @(negedge clk);
        while (!wordFull && n < 12) begin
            @(negedge clk);
            n++;
        end
        if (!wordFull) begin
            timeouts++;
            $display("timeout: wordFull did not rise after five letters in %s", name);
        end
        compareValue(name, "gameRdy before start", 0, gameRdy);
        @(posedge clk);
        #2;
        repeat (2) begin  // extra letters must be ignored
            randomCode(code);
            holdKey(code);
            releaseGap();
        end
        start = 1'b1;
        n = 0;
        @(negedge clk);
        while (!gameRdy && n < 12) begin
            @(negedge clk);
            n++;
        end
        if (!gameRdy) begin
            timeouts++;
            $display("timeout: gameRdy did not rise after start in %s", name);
        end
        compareValue(name, "wordFull", 1, wordFull);
        compareValue(name, "indexCorrect", 0, indexCorrect);
        @(posedge clk);
        #2 start = 1'b0;
    endtask

    task automatic makeGuess(input logic [keyCodeWidth-1:0] code, input string name);
        letterT             g;
        logic [wordLen-1:0] newMask;
        int                 hits;
        bit                 isMistake;
        bit                 dropped;
        int                 n;
        g       = letterBase + letterT'(code);
        dropped = (expCorrect == winCount) || (expIncorrect == loseCount);
        refGuess(expWord, expMask, g, newMask, hits, isMistake);
        obsMistakes   = 0;
        obsBusyCycles = 0;
        holdKey(code);
        if (dropped) begin
            repeat (10) begin
                @(negedge clk);
                if (busy) obsBusyCycles++;
                if (mistake) obsMistakes++;
            end
            expMistakes   = 0;
            expBusyCycles = 0;
        end else begin
            n = 0;
            @(negedge clk);
            while (!busy && n < 12) begin
                @(negedge clk);
                n++;
            end
            if (!busy) begin
                timeouts++;
                $display("timeout: busy did not rise for guess %s", name);
            end
            n = 0;
            while (!gameRdy && n < 12) begin
                if (busy) obsBusyCycles++;
                @(negedge clk);
                n++;
            end
            if (!gameRdy) begin
                timeouts++;
                $display("timeout: gameRdy did not return for guess %s", name);
            end
            obsMistakes += mistake;  // STOP cycle
            repeat (2) begin  // counts, then lamps
                @(negedge clk);
                obsMistakes += mistake;
            end
            expMask   = newMask;
            expLetter = g;
            if (hits > 0) expCorrect += hits;
            else expIncorrect++;
            expMistakes   = isMistake;
            expBusyCycles = wordLen;  // one scan cycle per position
            expGreen      = (expCorrect == winCount);
            expRed        = (expIncorrect == loseCount);
        end
        testName = name;
        -> checkEv;
        @(posedge clk);
        #2;
    endtask

    task automatic endGame(input string name);
        gameEnd = 1'b1;
        repeat (2) @(posedge clk);
        #2 gameEnd = 1'b0;
        @(negedge clk);
        compareValue(name, "correct", 0, correct);
        compareValue(name, "incorrect", 0, incorrect);
        compareValue(name, "indexCorrect", 0, indexCorrect);
        compareValue(name, "green", 0, green);
        compareValue(name, "red", 0, red);
        compareValue(name, "wordFull", 0, wordFull);
        compareValue(name, "gameRdy", 0, gameRdy);
        clearModel();
        @(posedge clk);
        #2;
    endtask

    always @(checkEv) begin
        compareValue(testName, "correct", expCorrect, correct);
        compareValue(testName, "incorrect", expIncorrect, incorrect);
        compareValue(testName, "indexCorrect", expMask, indexCorrect);
        compareValue(testName, "letter", expLetter, letter);
        compareValue(testName, "green", expGreen, green);
        compareValue(testName, "red", expRed, red);
        compareValue(testName, "mistake pulses", expMistakes, obsMistakes);
        compareValue(testName, "busy cycles", expBusyCycles, obsBusyCycles);
    end

    initial begin
        logic [keyCodeWidth-1:0] code;
        nRst     = 1'b0;
        keyCode  = '0;
        keyPress = 1'b0;
        start    = 1'b0;
        gameEnd  = 1'b0;
        clearModel();
        repeat (2) @(posedge clk);
        #2 nRst = 1'b1;
        @(negedge clk);
        compareValue("reset", "outputs",
                     40'h0, {letter, red, green, mistake, busy, gameRdy, wordFull});
        compareValue("reset", "counts", 40'h0, {incorrect, correct, indexCorrect});
        @(posedge clk);
        #2;

        loadWord("first word");
        makeGuess(codeAt(0), "first letter");
        makeGuess(codeAt(0), "repeat of revealed letter");
        makeGuess(absentCode(codeAt(1)), "absent letter");
        randomCode(code);
        makeGuess(code, "random letter");
        for (int i = 1; i < wordLen; i++) begin
            makeGuess(codeAt(i), "remaining letter");
        end
        randomCode(code);
        makeGuess(code, "guess after game over");
        endGame("new game");

        loadWord("second word");
        makeGuess(codeAt(2), "hit in second word");
        repeat (loseCount) begin
            randomCode(code);
            makeGuess(absentCode(code), "miss toward loss");
        end
        makeGuess(codeAt(0), "guess after loss");
        endGame("second new game");

        $display("checks %0d, value errors %0d, timeouts %0d", checkCount, valueErrors, timeouts);
        if ((valueErrors == 0) && (timeouts == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
